// File: include/edge_defines.svh
`ifndef EDGE_DEFINES_SVH
`define EDGE_DEFINES_SVH

// Image geometry. The result side loses one pixel on each border.
`define EDGE_IMG_W 32
`define EDGE_OUT_W 30
`define EDGE_PIX_W 8
`define EDGE_ADDR_W 10

// APB map, byte addresses with one 32-bit word per pixel or result.
`define EDGE_APB_AW 14
`define EDGE_IMG_BASE 14'h0000
`define EDGE_RES_BASE 14'h1000
`define EDGE_CTRL_ADDR 14'h2000
`define EDGE_STAT_ADDR 14'h2004

`endif

// File: source/edge_pkg.sv
`default_nettype none
`include "edge_defines.svh"

package edge_pkg;

    typedef logic signed [`EDGE_PIX_W-1:0] pixel_t;

    // Pixel 0 is the top left of the window, rows follow in order.
    typedef struct packed {
        pixel_t p0, p1, p2;
        pixel_t p3, p4, p5;
        pixel_t p6, p7, p8;
    } patch_t;

    typedef struct packed {
        logic [`EDGE_ADDR_W-1:0] a0, a1, a2;
        logic [`EDGE_ADDR_W-1:0] a3, a4, a5;
        logic [`EDGE_ADDR_W-1:0] a6, a7, a8;
    } window_addr_t;

    typedef struct packed {
        logic                    valid;
        logic [`EDGE_ADDR_W-1:0] addr;
        pixel_t                  data;
    } pixel_wr_t;

    typedef logic signed [11:0] grad_t; // Wide enough for +/-1020.

    typedef struct packed {
        logic                    valid;
        logic [`EDGE_ADDR_W-1:0] idx;
        logic [7:0]              mag;
    } result_wr_t;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`EDGE_APB_AW-1:0] paddr;
        logic [31:0]             pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: source/edge_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "edge_defines.svh"

module edge_apb_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire edge_pkg::apb_req_t   apb_req,
    output edge_pkg::apb_rsp_t        apb_rsp,
    output edge_pkg::pixel_wr_t       pixel_wr,
    input  wire edge_pkg::result_wr_t result_wr,
    output logic                   scan_start,
    input  wire                    scan_busy,
    input  wire                    scan_done
);

    logic        access;
    logic        aligned;
    logic [13:0] img_off;
    logic [13:0] res_off;
    logic        is_img;
    logic        is_res;
    logic        is_ctrl;
    logic        is_stat;
    logic        mapped;
    logic [7:0]  res_mem [0:`EDGE_OUT_W*`EDGE_OUT_W-1];

    assign access  = apb_req.psel && apb_req.penable; // Every access ends here, no wait states.
    assign aligned = (apb_req.paddr[1:0] == 2'b00);
    assign img_off = apb_req.paddr - `EDGE_IMG_BASE;
    assign res_off = apb_req.paddr - `EDGE_RES_BASE;

    // Offsets below a base wrap to large values and fall out of range.
    assign is_img  = aligned && (img_off < 14'(`EDGE_IMG_W*`EDGE_IMG_W*4));
    assign is_res  = aligned && (res_off < 14'(`EDGE_OUT_W*`EDGE_OUT_W*4));
    assign is_ctrl = (apb_req.paddr == `EDGE_CTRL_ADDR);
    assign is_stat = (apb_req.paddr == `EDGE_STAT_ADDR);
    assign mapped  = is_img || is_res || is_ctrl || is_stat;

    // The image may not change under a running scan.
    assign pixel_wr.valid = access && apb_req.pwrite && is_img && !scan_busy;
    assign pixel_wr.addr  = img_off[11:2];
    assign pixel_wr.data  = apb_req.pwdata[7:0];

    assign scan_start = access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0] && !scan_busy;

    always_comb begin
        apb_rsp.prdata = 32'd0;
        if (is_res) begin
            apb_rsp.prdata = {24'd0, res_mem[res_off[11:2]]};
        end else if (is_stat) begin
            apb_rsp.prdata = {30'd0, scan_done, scan_busy};
        end
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && is_img && scan_busy));

    always_ff @(posedge clk) begin
        if (result_wr.valid) begin
            res_mem[result_wr.idx] <= result_wr.mag;
        end
    end

    penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst) apb_req.penable |-> apb_req.psel
    ) else $error("APB penable high without psel.");

endmodule

`default_nettype wire

// File: source/pixel_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "edge_defines.svh"

module pixel_buffer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire edge_pkg::pixel_wr_t pixel_wr,
    input  wire [9:0]              addr1,
    input  wire [9:0]              addr2,
    output logic signed [7:0]      data1,
    output logic signed [7:0]      data2
);

    edge_pkg::pixel_t mem [0:`EDGE_IMG_W*`EDGE_IMG_W-1];

    always_ff @(posedge clk) begin
        if (pixel_wr.valid) begin
            mem[pixel_wr.addr] <= pixel_wr.data;
        end
    end

    // Both read ports are asynchronous so the patch latch sees data in the same cycle.
    assign data1 = mem[addr1];
    assign data2 = mem[addr2];

    // A write strobe from the bus side must carry a defined address and pixel.
    pixel_wr_known: assert property (
        @(posedge clk) disable iff (!rst) pixel_wr.valid |-> !$isunknown(pixel_wr)
    ) else $error("Pixel write with unknown address or data.");

endmodule

`default_nettype wire

// File: source/patch_data_latch.sv
`timescale 1ns/1ps
`default_nettype none

module patch_data_latch (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         load,
    input  wire                         load_full_patch,
    input  wire edge_pkg::window_addr_t window,
    input  wire signed [7:0]            data1,
    input  wire signed [7:0]            data2,
    output logic [9:0]                  addr1,
    output logic [9:0]                  addr2,
    output edge_pkg::patch_t            patch,
    output logic                        load_done
);

    // State 0 is idle, 1 to 5 each latch the pixels addressed the cycle before.
    logic [2:0] state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= 3'd0;
            load_done <= 1'b0;
        end else if (load && !load_done) begin
            case (state)
                3'd0: state <= load_full_patch ? 3'd1 : 3'd4; // A slide skips to the bottom row.
                3'd1, 3'd2, 3'd3, 3'd4: state <= state + 3'd1;
                3'd5: begin
                    state     <= 3'd0;
                    load_done <= 1'b1;
                end
                default: state <= 3'd0;
            endcase
        end else if (load) begin
            state     <= 3'd0;
            load_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load && !load_done) begin
            case (state)
                3'd0: begin
                    if (load_full_patch) begin
                        addr1 <= window.a0;
                        addr2 <= window.a1;
                    end else begin
                        addr1    <= window.a6;
                        addr2    <= window.a7;
                        patch.p0 <= patch.p3; // Rows one and two move up.
                        patch.p1 <= patch.p4;
                        patch.p2 <= patch.p5;
                        patch.p3 <= patch.p6;
                        patch.p4 <= patch.p7;
                        patch.p5 <= patch.p8;
                    end
                end
                3'd1: begin
                    patch.p0 <= data1;
                    patch.p1 <= data2;
                    addr1    <= window.a2;
                    addr2    <= window.a3;
                end
                3'd2: begin
                    patch.p2 <= data1;
                    patch.p3 <= data2;
                    addr1    <= window.a4;
                    addr2    <= window.a5;
                end
                3'd3: begin
                    patch.p4 <= data1;
                    patch.p5 <= data2;
                    addr1    <= window.a6;
                    addr2    <= window.a7;
                end
                3'd4: begin
                    patch.p6 <= data1;
                    patch.p7 <= data2;
                    addr1    <= window.a8; // Only one pixel left, port 2 idles.
                end
                3'd5: patch.p8 <= data1;
                default: ;
            endcase
        end
    end

    full_flag_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (load && state != 3'd0) |-> $stable(load_full_patch)
    ) else $error("load_full_patch changed during a patch fetch.");

endmodule

`default_nettype wire

// File: source/scan_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "edge_defines.svh"

module scan_controller (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       scan_start,
    input  wire                       load_done,
    input  wire                       mag_valid,
    input  wire [7:0]                 magnitude,
    output logic                      load,
    output logic                      load_full_patch,
    output edge_pkg::window_addr_t    window,
    output edge_pkg::result_wr_t      result_wr,
    output logic                      scan_busy,
    output logic                      scan_done
);

    localparam logic [4:0] LAST_POS = 5'(`EDGE_OUT_W - 1);
    localparam logic [9:0] ROW      = 10'(`EDGE_IMG_W);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_DRAIN} state_t;

    state_t     state;
    logic [4:0] x;
    logic [4:0] y;
    logic [9:0] base;
    logic [9:0] res_idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= S_IDLE;
            x         <= 5'd0;
            y         <= 5'd0;
            scan_done <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (scan_start) begin
                        state     <= S_LOAD;
                        x         <= 5'd0;
                        y         <= 5'd0;
                        scan_done <= 1'b0;
                    end
                end
                S_LOAD: begin
                    if (load_done) begin
                        if (y != LAST_POS) begin
                            y <= y + 5'd1;
                        end else if (x != LAST_POS) begin
                            x <= x + 5'd1; // Next column starts again at the top.
                            y <= 5'd0;
                        end else begin
                            state <= S_DRAIN;
                        end
                    end
                end
                S_DRAIN: begin
                    if (mag_valid) begin
                        state     <= S_IDLE;
                        scan_done <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // The window moves on at load_done, so its result index is kept for mag_valid.
    always_ff @(posedge clk) begin
        if (load && load_done) begin
            res_idx <= 10'(y) * 10'(`EDGE_OUT_W) + 10'(x);
        end
    end

    assign base = 10'(y) * ROW + 10'(x);

    always_comb begin
        window.a0 = base;
        window.a1 = base + 10'd1;
        window.a2 = base + 10'd2;
        window.a3 = base + ROW;
        window.a4 = base + ROW + 10'd1;
        window.a5 = base + ROW + 10'd2;
        window.a6 = base + 2 * ROW;
        window.a7 = base + 2 * ROW + 10'd1;
        window.a8 = base + 2 * ROW + 10'd2;
    end

    assign load            = (state == S_LOAD);
    assign load_full_patch = (y == 5'd0);
    assign scan_busy       = (state != S_IDLE);

    assign result_wr.valid = mag_valid;
    assign result_wr.idx   = res_idx;
    assign result_wr.mag   = magnitude;

    result_idx_range: assert property (
        @(posedge clk) disable iff (!rst)
        result_wr.valid |-> (result_wr.idx < 10'(`EDGE_OUT_W*`EDGE_OUT_W))
    ) else $error("Result index beyond the result memory.");

endmodule

`default_nettype wire

// File: source/sobel_gradient.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_gradient #(
    parameter bit VERTICAL = 1'b0
) (
    input  wire edge_pkg::patch_t patch,
    output edge_pkg::grad_t       grad
);

    edge_pkg::grad_t px [9];

    // Sign extension to the gradient width, so the sums below cannot overflow.
    assign px[0] = edge_pkg::grad_t'(patch.p0);
    assign px[1] = edge_pkg::grad_t'(patch.p1);
    assign px[2] = edge_pkg::grad_t'(patch.p2);
    assign px[3] = edge_pkg::grad_t'(patch.p3);
    assign px[4] = edge_pkg::grad_t'(patch.p4);
    assign px[5] = edge_pkg::grad_t'(patch.p5);
    assign px[6] = edge_pkg::grad_t'(patch.p6);
    assign px[7] = edge_pkg::grad_t'(patch.p7);
    assign px[8] = edge_pkg::grad_t'(patch.p8);

    if (VERTICAL) begin : g_vertical
        // Bottom row minus top row.
        assign grad = (px[6] + (px[7] <<< 1) + px[8]) - (px[0] + (px[1] <<< 1) + px[2]);
    end else begin : g_horizontal
        // Right column minus left column.
        assign grad = (px[2] + (px[5] <<< 1) + px[8]) - (px[0] + (px[3] <<< 1) + px[6]);
    end

endmodule

`default_nettype wire

// File: source/edge_magnitude.sv
`timescale 1ns/1ps
`default_nettype none

module edge_magnitude (
    input  wire                  clk,
    input  wire                  rst,
    input  wire edge_pkg::grad_t gx,
    input  wire edge_pkg::grad_t gy,
    input  wire                  load_done,
    output logic [7:0]           magnitude,
    output logic                 mag_valid
);

    logic [11:0] abs_x;
    logic [11:0] abs_y;
    logic [12:0] sum;

    assign abs_x = gx[11] ? 12'(-gx) : 12'(gx);
    assign abs_y = gy[11] ? 12'(-gy) : 12'(gy);
    assign sum   = {1'b0, abs_x} + {1'b0, abs_y};

    always_ff @(posedge clk) begin
        if (load_done) begin
            magnitude <= (sum > 13'd255) ? 8'hFF : sum[7:0]; // Saturate.
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mag_valid <= 1'b0;
        end else begin
            mag_valid <= load_done;
        end
    end

endmodule

`default_nettype wire

// File: source/edge_detect_top.sv
`timescale 1ns/1ps
`default_nettype none

module edge_detect_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire edge_pkg::apb_req_t apb_req,
    output edge_pkg::apb_rsp_t      apb_rsp
);

    edge_pkg::pixel_wr_t    pixel_wr;
    edge_pkg::result_wr_t   result_wr;
    edge_pkg::window_addr_t window;
    edge_pkg::patch_t       patch;
    edge_pkg::grad_t        gx;
    edge_pkg::grad_t        gy;
    logic                   scan_start;
    logic                   scan_busy;
    logic                   scan_done;
    logic [9:0]             addr1;
    logic [9:0]             addr2;
    logic signed [7:0]      data1;
    logic signed [7:0]      data2;
    logic                   load;
    logic                   load_full_patch;
    logic                   load_done;
    logic [7:0]             magnitude;
    logic                   mag_valid;

    edge_apb_regs u_regs (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .pixel_wr(pixel_wr), .result_wr(result_wr), .scan_start(scan_start),
        .scan_busy(scan_busy), .scan_done(scan_done)
    );

    pixel_buffer u_buffer (
        .clk(clk), .rst(rst), .pixel_wr(pixel_wr),
        .addr1(addr1), .addr2(addr2), .data1(data1), .data2(data2)
    );

    patch_data_latch u_latch (
        .clk(clk), .rst(rst), .load(load), .load_full_patch(load_full_patch),
        .window(window), .data1(data1), .data2(data2), .addr1(addr1), .addr2(addr2),
        .patch(patch), .load_done(load_done)
    );

    scan_controller u_scan (
        .clk(clk), .rst(rst), .scan_start(scan_start), .load_done(load_done),
        .mag_valid(mag_valid), .magnitude(magnitude), .load(load),
        .load_full_patch(load_full_patch), .window(window), .result_wr(result_wr),
        .scan_busy(scan_busy), .scan_done(scan_done)
    );

    sobel_gradient #(.VERTICAL(1'b0)) u_grad_x (.patch(patch), .grad(gx));
    sobel_gradient #(.VERTICAL(1'b1)) u_grad_y (.patch(patch), .grad(gy));

    edge_magnitude u_mag (
        .clk(clk), .rst(rst), .gx(gx), .gy(gy), .load_done(load_done),
        .magnitude(magnitude), .mag_valid(mag_valid)
    );

endmodule

`default_nettype wire

// File: sim/edge_detect_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "edge_defines.svh"

module edge_detect_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_PIX     = `EDGE_IMG_W * `EDGE_IMG_W;
    localparam int NUM_RES     = `EDGE_OUT_W * `EDGE_OUT_W;
    localparam int XFER_CYCLES = 3; // Setup, access and one idle cycle per APB transfer.

    // A column costs one full load of about 7 cycles and 29 slides of about 4.
    localparam int SCAN_CYCLES = `EDGE_OUT_W * (7 + (`EDGE_OUT_W - 1) * 4);

    // Two passes of image writes and result reads, with twice the scan time for each pass.
    localparam int TIMEOUT_CYCLES =
        2 * (XFER_CYCLES * (NUM_PIX + NUM_RES + 16) + 2 * SCAN_CYCLES);

    logic               clk;
    logic               rst;
    edge_pkg::apb_req_t apb_req;
    edge_pkg::apb_rsp_t apb_rsp;

    int seed;
    int cycles = 0;
    int img [0:NUM_PIX-1]; // Model copy of the image, signed pixels.

    edge_detect_top DUT (
        .clk(clk),
        .rst(rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("tests failed");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    // One APB transfer. The response is taken at the clock edge that ends the access phase.
    task automatic apb_transfer(input logic write, input logic [13:0] addr,
                                input logic [31:0] wdata, output logic [31:0] prdata,
                                output logic pslverr);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        prdata  = apb_rsp.prdata;
        pslverr = apb_rsp.pslverr;
        check_value("pready", 32'(apb_rsp.pready), 32'h1);
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [13:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] ignored;
        logic        got_err;
        apb_transfer(1'b1, addr, data, ignored, got_err);
        check_value("pslverr", 32'(got_err), 32'(exp_err));
    endtask

    task automatic apb_read(input logic [13:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic got_err;
        apb_transfer(1'b0, addr, 32'd0, data, got_err);
        check_value("pslverr", 32'(got_err), 32'(exp_err));
    endtask

    task automatic load_image();
        for (int i = 0; i < NUM_PIX; i++) begin
            apb_write(`EDGE_IMG_BASE + 14'(4 * i), 32'(img[i]), 1'b0);
        end
    endtask

    // Busy must hold until done rises, and the two never show together.
    task automatic wait_for_done();
        logic [31:0] status;
        logic        done_seen;
        done_seen = 1'b0;
        while (!done_seen) begin
            apb_read(`EDGE_STAT_ADDR, 1'b0, status);
            if (status[1]) begin
                check_value("status", status, 32'h2);
                done_seen = 1'b1;
            end else begin
                check_value("status", status, 32'h1);
            end
        end
    endtask

    function automatic int pix_at(input int r, input int c);
        return img[r * `EDGE_IMG_W + c];
    endfunction

    function automatic int expected_mag(input int r, input int c);
        int gx;
        int gy;
        int sum;
        gx = (pix_at(r, c + 2) + 2 * pix_at(r + 1, c + 2) + pix_at(r + 2, c + 2))
           - (pix_at(r, c) + 2 * pix_at(r + 1, c) + pix_at(r + 2, c));
        gy = (pix_at(r + 2, c) + 2 * pix_at(r + 2, c + 1) + pix_at(r + 2, c + 2))
           - (pix_at(r, c) + 2 * pix_at(r, c + 1) + pix_at(r, c + 2));
        sum = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        return (sum > 255) ? 255 : sum;
    endfunction

    task automatic check_results();
        logic [31:0] value;
        int          expected;
        for (int r = 0; r < `EDGE_OUT_W; r++) begin
            for (int c = 0; c < `EDGE_OUT_W; c++) begin
                apb_read(`EDGE_RES_BASE + 14'(4 * (r * `EDGE_OUT_W + c)), 1'b0, value);
                expected = expected_mag(r, c);
                check_value($sformatf("result[%0d][%0d]", r, c), value, 32'(expected));
            end
        end
    endtask

    initial begin
        logic signed [7:0] pix;
        logic [31:0]       value;
        clk     = 1'b0;
        rst     = 1'b0;
        apb_req = '0;
        seed    = 46;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        apb_read(`EDGE_STAT_ADDR, 1'b0, value);
        check_value("status", value, 32'h0);

        // Unmapped addresses: past STATUS, beyond the map, past the results, misaligned.
        apb_read(14'h2008, 1'b1, value);
        apb_write(14'h3000, 32'h1, 1'b1);
        apb_read(14'h1E10, 1'b1, value);
        apb_write(14'h0002, 32'h1, 1'b1);

        for (int i = 0; i < NUM_PIX; i++) begin
            pix    = $random(seed);
            img[i] = int'(pix);
        end
        load_image();
        apb_write(`EDGE_CTRL_ADDR, 32'h1, 1'b0);
        apb_read(`EDGE_STAT_ADDR, 1'b0, value);
        check_value("status", value, 32'h1);
        // The running scan rejects this pixel, so the model keeps the old one.
        apb_write(`EDGE_IMG_BASE + 14'(4 * 33), 32'(~img[33]), 1'b1);
        wait_for_done();
        check_results();

        // Stripes of the two extremes, changing along both rows and columns.
        for (int i = 0; i < NUM_PIX; i++) begin
            img[i] = (((i % `EDGE_IMG_W) / 4 + (i / `EDGE_IMG_W) / 8) % 2 == 1) ? 127 : -128;
        end
        load_image();
        apb_write(`EDGE_CTRL_ADDR, 32'h1, 1'b0);
        wait_for_done();
        check_results();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: edge_detect_top.f
+incdir+include
source/edge_pkg.sv
source/edge_apb_regs.sv
source/pixel_buffer.sv
source/patch_data_latch.sv
source/scan_controller.sv
source/sobel_gradient.sv
source/edge_magnitude.sv
source/edge_detect_top.sv
sim/edge_detect_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module edge_detect_tb -f edge_detect_top.f
	./obj_dir/Vedge_detect_tb | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
